// File: Bender.yml
package:
  name: esp_uart

sources:
  # Design, packages first
  - esp_line_pkg.sv
  - esp_host_pkg.sv
  - esp_uart_rx.sv
  - esp_sync_fifo.sv
  - esp_uart_tx.sv
  - esp_uart_link.sv

  # Simulation only
  - target: test
    files:
      - esp_uart_checker.sv
      - tb_esp_uart.sv

// File: esp_host_pkg.sv
package esp_host_pkg;

    // Host word, extra ninth bit of the core not carried
    localparam int HOST_W = 8;

    ////////////////////////////////////////////////////////////////////
    // FIFO pointer helpers
    ////////////////////////////////////////////////////////////////////
    // Pointer width for a power-of-two depth, never zero
    function automatic int ptr_w(input int depth);
        return (depth > 1) ? $clog2(depth) : 1;
    endfunction

    // Occupancy counter width, one extra bit to hold a full count
    function automatic int cnt_w(input int depth);
        return ptr_w(depth) + 1;
    endfunction

endpackage

// File: esp_line_pkg.sv
package esp_line_pkg;

    ////////////////////////////////////////////////////////////////////
    // Frame layout, 8N1, LSB first
    ////////////////////////////////////////////////////////////////////
    localparam int DATA_BITS  = 8;              // Payload bits per frame
    localparam int FRAME_BITS = DATA_BITS + 2;  // Start + data + stop

    localparam logic START_BIT = 1'b0;          // Line level of start bit
    localparam logic STOP_BIT  = 1'b1;          // Line level of stop bit, also idle

    ////////////////////////////////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////////////////////////////////
    // Receiver
    typedef enum logic [1:0] {
        RX_IDLE,    // Waiting for falling edge
        RX_START,   // Half bit, start level recheck
        RX_DATA,    // Sampling data bits
        RX_STOP     // Stop bit sample
    } rx_state_e;

    // Transmitter
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

// File: esp_sync_fifo.sv
`timescale 1ns/1ps

module esp_sync_fifo #(
    parameter int DEPTH = 16,                       // Power of two
    parameter int WIDTH = esp_host_pkg::HOST_W
) (
    input  logic                                    clk,
    input  logic                                    arst_n,

    // Write side
    input  logic [WIDTH-1:0]                        wr_data,
    input  logic                                    wr_en,

    // Read side, head entry always presented
    input  logic                                    rd_en,
    output logic [WIDTH-1:0]                        rd_data,

    // Status
    output logic                                    full,
    output logic                                    empty,
    output logic [esp_host_pkg::cnt_w(DEPTH)-1:0]   count
);
    import esp_host_pkg::*;

    localparam int PTR_W = ptr_w(DEPTH);
    localparam int CNT_W = cnt_w(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] cnt_q;
    logic             do_wr;
    logic             do_rd;

    assign full  = (cnt_q == CNT_W'(DEPTH));
    assign empty = (cnt_q == '0);
    assign count = cnt_q;

    // Full FIFO still takes a write when read in the same cycle
    assign do_rd = rd_en && !empty;
    assign do_wr = wr_en && (!full || rd_en);

    ////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt_q  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;    // Wraps at DEPTH
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;

            case ({do_wr, do_rd})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;           // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_ptr];   // Write visible the cycle after

endmodule

// File: esp_uart.f
esp_line_pkg.sv
esp_host_pkg.sv
esp_uart_rx.sv
esp_sync_fifo.sv
esp_uart_tx.sv
esp_uart_link.sv
esp_uart_checker.sv
tb_esp_uart.sv

// File: esp_uart_checker.sv
`timescale 1ns/1ps

module esp_uart_checker #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            esp_tx,
    input  logic [esp_host_pkg::HOST_W-1:0] rx_data,
    input  logic                            rx_valid,
    input  logic                            rx_ready,
    input  logic                            rx_overflow,
    input  logic                            rx_framing_error,
    input  esp_line_pkg::rx_state_e         rx_state,   // Debug only
    output int                              error_count
);
    import esp_line_pkg::*;
    import esp_host_pkg::*;

    logic [FRAME_BITS-1:0] tx_exp_q[$];     // Expected line patterns
    logic [HOST_W-1:0]     rx_exp_q[$];     // Expected host bytes
    logic [HOST_W-1:0]     rx_want;
    int errors    = 0;
    int ferr_want = 0;
    int ferr_seen = 0;
    int ovf_want  = 0;
    int ovf_seen  = 0;

    assign error_count = errors;

    //////////////////////////////////////////////////////////////////////
    // Bench side hooks
    //////////////////////////////////////////////////////////////////////
    task automatic push_tx_frame(input logic [FRAME_BITS-1:0] frame);
        tx_exp_q.push_back(frame);
    endtask

    task automatic push_rx_byte(input logic [HOST_W-1:0] b);
        rx_exp_q.push_back(b);
    endtask

    task automatic add_framing_error();
        ferr_want++;
    endtask

    task automatic add_overflow();
        ovf_want++;
    endtask

    function automatic int tx_left();
        return tx_exp_q.size();
    endfunction

    function automatic int rx_left();
        return rx_exp_q.size();
    endfunction

    // Leftovers and pulse totals
    task automatic final_check();
        if (tx_exp_q.size() != 0) begin
            errors++;
            $display("%0d frames were written but never appeared on esp_tx", tx_exp_q.size());
        end
        if (rx_exp_q.size() != 0) begin
            errors++;
            $display("%0d bytes were sent but never reached the host", rx_exp_q.size());
        end
        if (ferr_seen != ferr_want) begin
            errors++;
            $display("Expected %0d framing error pulses but saw %0d", ferr_want, ferr_seen);
        end
        if (ovf_seen != ovf_want) begin
            errors++;
            $display("Expected %0d overflow pulses but saw %0d", ovf_want, ovf_seen);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // esp_tx deserialiser, mid-bit samples on the falling edge
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [FRAME_BITS-1:0] got;
        logic [FRAME_BITS-1:0] want;
        logic                  prev;
        int                    i;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (arst_n && prev && !esp_tx) begin    // Start bit edge
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                for (i = 0; i < FRAME_BITS; i++) begin
                    if (i > 0) repeat (CLKS_PER_BIT) @(negedge clk);
                    got[i] = esp_tx;
                end
                if (tx_exp_q.size() == 0) begin
                    errors++;
                    $display("Frame %b appeared on esp_tx at %0t with nothing queued", got, $time);
                end else begin
                    want = tx_exp_q.pop_front();
                    if (got !== want) begin
                        errors++;
                        $display("FAIL @%0t: esp_tx frame %b, expected %b", $time, got, want);
                    end
                end
            end
            prev = esp_tx;
        end
    end

    // Host receive handshake and status pulses
    always @(posedge clk) begin
        if (arst_n) begin
            if (rx_framing_error) ferr_seen++;
            if (rx_overflow)      ovf_seen++;
            if (rx_valid && rx_ready) begin
                if (rx_exp_q.size() == 0) begin
                    errors++;
                    $display("Host got byte 0x%02h at %0t that was never sent", rx_data, $time);
                end else begin
                    rx_want = rx_exp_q.pop_front();
                    if (rx_data !== rx_want) begin
                        errors++;
                        $display("FAIL @%0t: rx_data 0x%02h, expected 0x%02h (receiver %s)",
                                 $time, rx_data, rx_want, rx_state.name());
                    end
                end
            end
        end
    end

endmodule

// File: esp_uart_link.sv
`timescale 1ns/1ps

module esp_uart_link #(
    parameter int CLKS_PER_BIT = 248,   // Clocks per serial bit
    parameter int FIFO_DEPTH   = 16,    // Entries per FIFO, power of two
    parameter int RTS_MARGIN   = 2      // Free entries left when RTS rises
) (
    input  logic                            clk,
    input  logic                            arst_n,

    // ESP32 serial line
    input  logic                            esp_rx,
    output logic                            esp_tx,
    input  logic                            esp_cts,
    output logic                            esp_rts,

    // Host transmit
    input  logic [esp_host_pkg::HOST_W-1:0] tx_data,
    input  logic                            tx_valid,
    output logic                            tx_ready,

    // Host receive
    output logic [esp_host_pkg::HOST_W-1:0] rx_data,
    output logic                            rx_valid,
    input  logic                            rx_ready,

    // Status pulses
    output logic                            rx_overflow,
    output logic                            rx_framing_error
);
    import esp_host_pkg::*;

    localparam int CNT_W     = cnt_w(FIFO_DEPTH);
    localparam int RTS_LEVEL = FIFO_DEPTH - RTS_MARGIN;

    logic [HOST_W-1:0] rx_byte_data;
    logic              rx_byte_valid;
    logic              rx_fifo_full;
    logic              rx_fifo_empty;
    logic [CNT_W-1:0]  rx_fifo_count;
    logic              rx_rd;

    logic [HOST_W-1:0] tx_fifo_data;
    logic              tx_fifo_full;
    logic              tx_fifo_empty;
    logic              tx_in_ready;
    logic              tx_rd;

    ////////////////////////////////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////////////////////////////////
    esp_uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx (
        .clk           (clk),
        .arst_n        (arst_n),
        .esp_rx        (esp_rx),
        .byte_data     (rx_byte_data),
        .byte_valid    (rx_byte_valid),
        .framing_error (rx_framing_error)
    );

    assign rx_valid = !rx_fifo_empty;
    assign rx_rd    = rx_valid && rx_ready;

    esp_sync_fifo #(
        .DEPTH (FIFO_DEPTH),
        .WIDTH (HOST_W)
    ) u_rx_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_data (rx_byte_data),
        .wr_en   (rx_byte_valid),
        .rd_en   (rx_rd),
        .rd_data (rx_data),
        .full    (rx_fifo_full),
        .empty   (rx_fifo_empty),
        .count   (rx_fifo_count)
    );

    // Byte lost, same cycle as the receiver strobe
    assign rx_overflow = rx_byte_valid && rx_fifo_full && !rx_rd;

    // RTS raised near full so the ESP32 stops sending
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            esp_rts <= 1'b0;
        end else begin
            esp_rts <= (rx_fifo_count >= CNT_W'(RTS_LEVEL));
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////////////////////////////////
    assign tx_ready = !tx_fifo_full;
    assign tx_rd    = !tx_fifo_empty && tx_in_ready;

    esp_sync_fifo #(
        .DEPTH (FIFO_DEPTH),
        .WIDTH (HOST_W)
    ) u_tx_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_data (tx_data),
        .wr_en   (tx_valid && tx_ready),
        .rd_en   (tx_rd),
        .rd_data (tx_fifo_data),
        .full    (tx_fifo_full),
        .empty   (tx_fifo_empty),
        .count   ()                      // Level not needed on this side
    );

    esp_uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_data  (tx_fifo_data),
        .in_valid (!tx_fifo_empty),
        .in_ready (tx_in_ready),
        .esp_cts  (esp_cts),
        .esp_tx   (esp_tx)
    );

endmodule

// File: esp_uart_rx.sv
`timescale 1ns/1ps

module esp_uart_rx #(
    parameter int CLKS_PER_BIT = 248        // Clocks per serial bit
) (
    input  logic                            clk,
    input  logic                            arst_n,

    // Serial input from ESP32
    input  logic                            esp_rx,

    // Received byte, one-cycle strobes
    output logic [esp_host_pkg::HOST_W-1:0] byte_data,
    output logic                            byte_valid,
    output logic                            framing_error
);
    import esp_line_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int IDX_W = $clog2(DATA_BITS);

    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(DATA_BITS - 1);

    logic [2:0]           rx_sync;      // [1:0] synchroniser, [2] previous level
    logic                 rx_s;         // Synchronised line
    logic                 rx_fall;      // High to low on synced line
    rx_state_e            state_q;
    logic [CNT_W-1:0]     cnt_q;        // Clocks within current bit
    logic [IDX_W-1:0]     idx_q;        // Data bit index
    logic [DATA_BITS-1:0] shift_q;      // LSB first, shifts in from the top
    logic                 sample;       // Mid-bit data sample strobe

    ////////////////////////////////////////////////////////////////////
    // Input synchroniser and edge detect
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 3'b111;      // Idle line is high
        end else begin
            rx_sync <= {rx_sync[1:0], esp_rx};
        end
    end

    assign rx_s    = rx_sync[1];
    assign rx_fall = rx_sync[2] & ~rx_sync[1];

    ////////////////////////////////////////////////////////////////////
    // Receive FSM
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= RX_IDLE;
            cnt_q         <= '0;
            idx_q         <= '0;
            byte_valid    <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            byte_valid    <= 1'b0;  // Strobes last one cycle
            framing_error <= 1'b0;

            case (state_q)
                RX_IDLE: begin
                    if (rx_fall) begin
                        state_q <= RX_START;
                        cnt_q   <= '0;
                    end
                end

                RX_START: begin
                    if (cnt_q == HALF_LAST) begin
                        cnt_q <= '0;
                        idx_q <= '0;
                        // Glitch if line went back high
                        state_q <= (rx_s == START_BIT) ? RX_DATA : RX_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                RX_DATA: begin
                    if (cnt_q == BIT_LAST) begin
                        cnt_q <= '0;
                        if (idx_q == IDX_LAST) begin
                            state_q <= RX_STOP;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                RX_STOP: begin
                    if (cnt_q == BIT_LAST) begin
                        cnt_q   <= '0;
                        state_q <= RX_IDLE;
                        if (rx_s == STOP_BIT) begin
                            byte_valid <= 1'b1;
                        end else begin
                            framing_error <= 1'b1;   // Byte dropped
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Data shift register
    assign sample = (state_q == RX_DATA) && (cnt_q == BIT_LAST);

    always_ff @(posedge clk) begin
        if (sample) begin
            shift_q <= {rx_s, shift_q[DATA_BITS-1:1]};
        end
    end

    assign byte_data = shift_q;    // Stable until next frame's first data bit

endmodule

// File: esp_uart_tx.sv
`timescale 1ns/1ps

module esp_uart_tx #(
    parameter int CLKS_PER_BIT = 248
) (
    input  logic                            clk,
    input  logic                            arst_n,

    // Byte stream from transmit FIFO
    input  logic [esp_host_pkg::HOST_W-1:0] in_data,
    input  logic                            in_valid,
    output logic                            in_ready,

    // Serial side
    input  logic                            esp_cts,   // High asks us to pause
    output logic                            esp_tx
);
    import esp_line_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int IDX_W = $clog2(DATA_BITS);

    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_BITS - 1);

    logic [1:0]            cts_sync;
    logic                  cts_q;       // Synchronised CTS
    tx_state_e             state_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [IDX_W-1:0]      idx_q;
    logic [FRAME_BITS-1:0] frame_q;     // Bit 0 is on the line
    logic                  load;
    logic                  bit_end;

    // CTS only matters before a frame starts
    assign cts_q    = cts_sync[1];
    assign in_ready = (state_q == TX_IDLE) && !cts_q;
    assign load     = in_valid && in_ready;
    assign bit_end  = (state_q != TX_IDLE) && (cnt_q == BIT_LAST);
    assign esp_tx   = frame_q[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cts_sync <= 2'b00;
        end else begin
            cts_sync <= {cts_sync[0], esp_cts};
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Transmit FSM and frame shifter
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= TX_IDLE;
            cnt_q   <= '0;
            idx_q   <= '0;
            frame_q <= '1;              // Line idles high
        end else begin
            // Bit period counter
            if (state_q == TX_IDLE || bit_end) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end

            if (load) begin
                frame_q <= {STOP_BIT, in_data, START_BIT};
            end else if (bit_end) begin
                frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};   // Refill with idle
            end

            case (state_q)
                TX_IDLE:  if (load) state_q <= TX_START;
                TX_START: begin
                    if (bit_end) begin
                        state_q <= TX_DATA;
                        idx_q   <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (idx_q == IDX_LAST) state_q <= TX_STOP;
                        else                   idx_q   <= idx_q + 1'b1;
                    end
                end
                TX_STOP:  if (bit_end) state_q <= TX_IDLE;   // Frame always finishes
                default:  state_q <= TX_IDLE;
            endcase
        end
    end

endmodule

// File: tb_esp_uart.sv
`timescale 1ns/1ps

module tb_esp_uart;
    import esp_line_pkg::*;
    import esp_host_pkg::*;

    localparam int CLKS     = 8;        // Short bit period for simulation
    localparam int DEPTH    = 8;
    localparam int N_FRAMES = 65;       // All frames plus the CTS hold window
    localparam int LIMIT    = N_FRAMES * FRAME_BITS * CLKS * 3 + 200;

    logic              clk;
    logic              arst_n;
    logic              esp_rx;
    logic              esp_tx;
    logic              esp_cts;
    logic              esp_rts;
    logic [HOST_W-1:0] tx_data;
    logic              tx_valid;
    logic              tx_ready;
    logic [HOST_W-1:0] rx_data;
    logic              rx_valid;
    logic              rx_ready;
    logic              rx_overflow;
    logic              rx_framing_error;
    int                chk_errors;
    int                bench_errors = 0;
    int                cycles       = 0;
    int                seed         = 32'hebb1_aefd;

    esp_uart_link #(
        .CLKS_PER_BIT (CLKS),
        .FIFO_DEPTH   (DEPTH)
    ) u_dut (
        .clk (clk), .arst_n (arst_n),
        .esp_rx (esp_rx), .esp_tx (esp_tx), .esp_cts (esp_cts), .esp_rts (esp_rts),
        .tx_data (tx_data), .tx_valid (tx_valid), .tx_ready (tx_ready),
        .rx_data (rx_data), .rx_valid (rx_valid), .rx_ready (rx_ready),
        .rx_overflow (rx_overflow), .rx_framing_error (rx_framing_error)
    );

    esp_uart_checker #(
        .CLKS_PER_BIT (CLKS)
    ) u_chk (
        .clk (clk), .arst_n (arst_n), .esp_tx (esp_tx),
        .rx_data (rx_data), .rx_valid (rx_valid), .rx_ready (rx_ready),
        .rx_overflow (rx_overflow), .rx_framing_error (rx_framing_error),
        .rx_state (u_dut.u_rx.state_q), .error_count (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Run did not finish within %0d cycles", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and drivers
    //////////////////////////////////////////////////////////////////////
    // Line pattern, bit 0 sent first: start, data LSB first, stop
    function automatic logic [FRAME_BITS-1:0] uart_frame(input logic [HOST_W-1:0] b);
        return {1'b1, b, 1'b0};
    endfunction

    task automatic check_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            bench_errors++;
            $display("FAIL @%0t: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic host_write(input logic [HOST_W-1:0] b);
        u_chk.push_tx_frame(uart_frame(b));
        tx_data  = b;
        tx_valid = 1'b1;
        while (!tx_ready) @(negedge clk);
        @(negedge clk);
        tx_valid = 1'b0;
    endtask

    // ESP32 side frame on esp_rx, optional bad stop bit
    task automatic serial_send(input logic [HOST_W-1:0] b, input logic bad_stop);
        logic [FRAME_BITS-1:0] f;
        int                    i;
        f = uart_frame(b);
        if (bad_stop) f[FRAME_BITS-1] = 1'b0;
        for (i = 0; i < FRAME_BITS; i++) begin
            esp_rx = f[i];
            repeat (CLKS) @(negedge clk);
        end
        esp_rx = 1'b1;
        if (bad_stop) repeat (2 * CLKS) @(negedge clk);   // Idle so next start has an edge
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [HOST_W-1:0] b;
        int                k;
        arst_n   = 1'b0;
        esp_rx   = 1'b1;
        esp_cts  = 1'b0;
        tx_data  = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b1;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Idle levels after reset
        check_level("esp_tx", esp_tx, 1'b1);
        check_level("esp_rts", esp_rts, 1'b0);
        check_level("rx_valid", rx_valid, 1'b0);
        check_level("tx_ready", tx_ready, 1'b1);

        // Host to line, twenty bytes
        for (k = 0; k < 20; k++) host_write(8'($random(seed)));
        while (u_chk.tx_left() != 0) @(negedge clk);

        // Line to host, twenty bytes
        for (k = 0; k < 20; k++) begin
            b = 8'($random(seed));
            u_chk.push_rx_byte(b);
            serial_send(b, 1'b0);
        end
        while (u_chk.rx_left() != 0) @(negedge clk);

        // Bad stop bit, then normal traffic
        u_chk.add_framing_error();
        serial_send(8'($random(seed)), 1'b1);
        for (k = 0; k < 2; k++) begin
            b = 8'($random(seed));
            u_chk.push_rx_byte(b);
            serial_send(b, 1'b0);
        end
        while (u_chk.rx_left() != 0) @(negedge clk);

        // Host stalls: RTS at six stored, overflow past eight
        rx_ready = 1'b0;
        for (k = 0; k < 10; k++) begin
            b = 8'($random(seed));
            if (k < DEPTH) u_chk.push_rx_byte(b);
            else           u_chk.add_overflow();
            serial_send(b, 1'b0);
            if (k == 4 || k == 5) repeat (2) @(negedge clk);   // Registered RTS settles
            if (k == 4) check_level("esp_rts", esp_rts, 1'b0);
            if (k == 5) check_level("esp_rts", esp_rts, 1'b1);
        end
        rx_ready = 1'b1;
        while (rx_valid) @(negedge clk);
        repeat (2) @(negedge clk);
        check_level("esp_rts", esp_rts, 1'b0);

        // CTS raised mid-frame, frame must still complete
        host_write(8'($random(seed)));
        while (esp_tx) @(negedge clk);
        repeat (3 * CLKS) @(negedge clk);
        esp_cts = 1'b1;
        while (u_chk.tx_left() != 0) @(negedge clk);

        // CTS held, nothing leaves and the FIFO fills up
        host_write(8'($random(seed)));
        for (k = 0; k < 3 * FRAME_BITS * CLKS; k++) begin
            @(negedge clk);
            if (!esp_tx) begin
                bench_errors++;
                $display("Start bit sent at %0t while esp_cts was high", $time);
                break;
            end
        end
        for (k = 1; k < DEPTH; k++) host_write(8'($random(seed)));
        check_level("tx_ready", tx_ready, 1'b0);
        check_level("esp_tx", esp_tx, 1'b1);
        esp_cts = 1'b0;
        while (u_chk.tx_left() != 0) @(negedge clk);
        repeat (CLKS) @(negedge clk);

        u_chk.final_check();
        @(negedge clk);
        $display("Checks done, bench errors %0d, checker errors %0d", bench_errors, chk_errors);
        if (bench_errors == 0 && chk_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
